// File: verilog/krz_map.sv
// ================================================
// System address map, UART timing and bus request types
// Imported by the bridge, the peripherals and the testbench
// ================================================

package krz_map;

    // ================================================
    // Address map

    // Page field sits in address bits 15:8
    localparam int PAGE_LSB = 8;
    localparam int PAGE_W   = 8;

    // One-hot page bits, 0x800100 and 0x800200
    localparam int PAGE_GPREG = 0;
    localparam int PAGE_UART  = 1;

    // ================================================
    // Peripheral constants

    // Identification word at GPREG index 0
    localparam logic [31:0] GPREG_ID = 32'h4b52_5a31;
    localparam int GPREG_COUNT = 8;
    localparam int GPREG_IDX_W = 3;

    // Serial bit time in clocks
    localparam int UART_CLKS_PER_BIT = 8;
    localparam int UART_CNT_W = $clog2(UART_CLKS_PER_BIT);

    // ================================================
    // Bus request structs

    // Crossbar side, held stable while stb is high
    typedef struct packed {
        logic [23:0] adr;
        logic [31:0] dat;
        logic        we;
        logic [3:0]  sel;
        logic        stb;
    } sys_req_t;

    // GPREG side, always a full word
    typedef struct packed {
        logic [7:0]  adr;
        logic [31:0] dat;
        logic        we;
        logic        stb;
    } gpreg_req_t;

endpackage

// File: verilog/krz_sysbus.sv
// ================================================
// System page bridge from the crossbar to GPREG and UART
// Checks each request, then runs it as one word or as byte steps
// ================================================

`timescale 1ns/1ns

module krz_sysbus (
    input  logic                clk,
    input  logic                rstz,
    // Crossbar
    input  krz_map::sys_req_t   sys_req_i,
    output logic [31:0]         sys_dat_o,
    output logic                sys_ack_o,
    output logic                sys_err_o,
    // GPREG
    output krz_map::gpreg_req_t gpreg_req_o,
    input  logic [31:0]         gpreg_dat_i,
    input  logic                gpreg_ack_i,
    // UART
    output logic [7:0]          uart_dat_o,
    output logic                uart_we_o,
    output logic                uart_stb_o,
    input  logic [7:0]          uart_dat_i,
    input  logic                uart_ack_i
);
    import krz_map::*;

    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_GPREG,
        GNT_UART
    } gnt_t;

    typedef enum logic [2:0] {
        IDLE,
        READ8,
        WRITE8,
        READ32,
        WRITE32,
        ACK,
        ERROR
    } state_t;

    logic [PAGE_W-1:0] page;
    logic sel_valid;
    logic align_valid;
    logic page_gpreg;
    logic page_uart;
    logic req_valid;

    gnt_t   gnt;
    state_t state, next_state;
    logic   gpreg_stb;

    // Latched transaction
    logic        is_write;
    logic [7:0]  addr;
    logic [31:0] data;
    // Bytes still pending after the current one
    logic [3:1]  more;

    // Muxed peripheral response
    logic [31:0] read_data;
    logic        ack;

    // ================================================
    // Request check

    // Only 1, 2 or 4 bytes from lane 0 upward
    assign sel_valid = (sys_req_i.sel == 4'b0001) ||
                       (sys_req_i.sel == 4'b0011) ||
                       (sys_req_i.sel == 4'b1111);
    assign align_valid = (sys_req_i.adr[1:0] == 2'b00);

    // Exactly one known page bit
    assign page       = sys_req_i.adr[PAGE_LSB +: PAGE_W];
    assign page_gpreg = (page == (PAGE_W'(1) << PAGE_GPREG));
    assign page_uart  = (page == (PAGE_W'(1) << PAGE_UART));

    assign req_valid = sel_valid & align_valid & (page_gpreg | page_uart);

    // ================================================
    // Grant and peripheral strobes

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            gnt        <= GNT_NONE;
            gpreg_stb  <= 1'b0;
            uart_stb_o <= 1'b0;
        end else if (state == IDLE && sys_req_i.stb && req_valid) begin
            if (page_gpreg) begin
                gnt       <= GNT_GPREG;
                gpreg_stb <= 1'b1;
            end else begin
                gnt        <= GNT_UART;
                uart_stb_o <= 1'b1;
            end
        end else if (next_state == ACK) begin
            // Last ack taken, release the peripheral
            gnt        <= GNT_NONE;
            gpreg_stb  <= 1'b0;
            uart_stb_o <= 1'b0;
        end
    end

    // ================================================
    // Transaction FSM

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (sys_req_i.stb) begin
                    if (!req_valid) begin
                        next_state = ERROR;
                    end else if (page_gpreg) begin
                        next_state = sys_req_i.we ? WRITE32 : READ32;
                    end else begin
                        next_state = sys_req_i.we ? WRITE8 : READ8;
                    end
                end
            end
            READ32, WRITE32: begin
                if (ack) next_state = ACK;
            end
            // Done once no byte is left behind the current one
            READ8, WRITE8: begin
                if (ack && !more[1]) next_state = ACK;
            end
            // Error strobe goes out while ACK holds off the dropped stb
            ERROR:   next_state = ACK;
            ACK:     next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // ================================================
    // Data and byte sequencing

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (sys_req_i.stb && req_valid) begin
                    is_write <= sys_req_i.we;
                    // Reads start from zero so bytes shift into a clean word
                    data     <= sys_req_i.we ? sys_req_i.dat : 32'h0;
                    addr     <= sys_req_i.adr[7:0];
                    more     <= sys_req_i.sel[3:1];
                end
            end
            READ32: begin
                if (ack) data <= read_data;
            end
            WRITE8: begin
                if (ack) begin
                    // Next byte down into lane 0
                    data <= {8'h0, data[31:8]};
                    more <= {1'b0, more[3:2]};
                end
            end
            READ8: begin
                if (ack) begin
                    // New byte in from the bottom
                    data <= {data[23:0], read_data[7:0]};
                    more <= {1'b0, more[3:2]};
                end
            end
            default: begin
            end
        endcase
    end

    // ================================================
    // Peripheral wiring

    assign gpreg_req_o.adr = addr;
    assign gpreg_req_o.dat = data;
    assign gpreg_req_o.we  = is_write;
    assign gpreg_req_o.stb = gpreg_stb;

    assign uart_dat_o = data[7:0];
    assign uart_we_o  = is_write;

    // Response from the granted peripheral only
    always_comb begin
        case (gnt)
            GNT_GPREG: begin
                ack       = gpreg_ack_i;
                read_data = gpreg_dat_i;
            end
            GNT_UART: begin
                ack       = uart_ack_i;
                read_data = {24'h0, uart_dat_i};
            end
            default: begin
                ack       = 1'b0;
                read_data = 32'h0;
            end
        endcase
    end

    // ================================================
    // Crossbar response

    // One-cycle strobes, registered
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            sys_ack_o <= 1'b0;
            sys_err_o <= 1'b0;
        end else begin
            sys_ack_o <= (next_state == ACK) && (state != ERROR);
            sys_err_o <= (state == ERROR);
        end
    end

    assign sys_dat_o = data;

endmodule

// File: verilog/krz_gpreg.sv
// ================================================
// Eight general-purpose 32-bit registers on the system page
// Index 0 is a read-only ID word, the rest are read/write
// ================================================

`timescale 1ns/1ns

module krz_gpreg (
    input  logic                clk,
    input  logic                rstz,
    input  krz_map::gpreg_req_t req_i,
    output logic [31:0]         dat_o,
    output logic                ack_o
);
    import krz_map::*;

    logic [31:0] regs [1:GPREG_COUNT-1];
    logic [GPREG_IDX_W-1:0] idx;
    logic [31:0] rd_word;
    logic        access;

    // Word index from address bits 4:2
    assign idx = req_i.adr[2 +: GPREG_IDX_W];

    // One access per strobe, the ack cycle blocks a repeat
    assign access = req_i.stb & ~ack_o;

    // Index 0 falls through to the ID
    always_comb begin
        rd_word = GPREG_ID;
        for (int i = 1; i < GPREG_COUNT; i++) begin
            if (idx == GPREG_IDX_W'(i)) rd_word = regs[i];
        end
    end

    // ================================================
    // Register file and ack

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            ack_o <= 1'b0;
            for (int i = 1; i < GPREG_COUNT; i++) begin
                regs[i] <= 32'h0;
            end
        end else begin
            ack_o <= access;
            // Writes to index 0 are dropped
            for (int i = 1; i < GPREG_COUNT; i++) begin
                if (access && req_i.we && idx == GPREG_IDX_W'(i)) begin
                    regs[i] <= req_i.dat;
                end
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (access) dat_o <= rd_word;
    end

endmodule

// File: verilog/krz_uart.sv
// ================================================
// Byte-wide 8N1 UART with a one-byte receive holding register
// Strobed by the bridge, ack paces each byte
// ================================================

`timescale 1ns/1ns

module krz_uart (
    input  logic       clk,
    input  logic       rstz,
    input  logic [7:0] dat_i,
    input  logic       we_i,
    input  logic       stb_i,
    output logic [7:0] dat_o,
    output logic       ack_o,
    input  logic       rx_i,
    output logic       tx_o
);
    import krz_map::*;

    localparam logic [UART_CNT_W-1:0] BIT_LAST = UART_CNT_W'(UART_CLKS_PER_BIT - 1);
    localparam logic [UART_CNT_W-1:0] BIT_HALF = UART_CNT_W'(UART_CLKS_PER_BIT / 2);

    // Transmitter
    logic [9:0]            tx_frame;
    logic [3:0]            tx_bits;
    logic [UART_CNT_W-1:0] tx_cnt;
    logic                  tx_busy;
    logic                  tx_load;

    // Receiver
    logic [1:0]            rx_sync;
    logic                  rx_bit;
    logic                  rx_active;
    logic [3:0]            rx_idx;
    logic [UART_CNT_W-1:0] rx_cnt;
    logic [7:0]            rx_shift;
    logic [7:0]            rx_hold;
    logic                  rx_valid;
    logic                  rx_done;
    logic                  rd_take;

    // ================================================
    // Bus side

    assign tx_busy = (tx_bits != 4'd0);
    assign tx_load = stb_i & we_i & ~tx_busy & ~ack_o;
    assign rd_take = stb_i & ~we_i & rx_valid & ~ack_o;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= tx_load | rd_take;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) dat_o <= rx_hold;
    end

    // ================================================
    // Transmitter

    // Stop, data LSB first, start, shifted out from bit 0
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            tx_frame <= '1;
            tx_bits  <= 4'd0;
            tx_cnt   <= '0;
        end else if (tx_load) begin
            tx_frame <= {1'b1, dat_i, 1'b0};
            tx_bits  <= 4'd10;
            tx_cnt   <= '0;
        end else if (tx_busy) begin
            if (tx_cnt == BIT_LAST) begin
                tx_cnt   <= '0;
                tx_frame <= {1'b1, tx_frame[9:1]};
                tx_bits  <= tx_bits - 4'd1;
            end else begin
                tx_cnt <= tx_cnt + 1'b1;
            end
        end
    end

    // Idle high
    assign tx_o = tx_frame[0];

    // ================================================
    // Receiver

    assign rx_bit = rx_sync[1];

    // Stop bit sampled high
    assign rx_done = rx_active && (rx_cnt == BIT_LAST) && (rx_idx == 4'd9) && rx_bit;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            rx_sync   <= 2'b11;
            rx_active <= 1'b0;
            rx_idx    <= 4'd0;
            rx_cnt    <= '0;
        end else begin
            rx_sync <= {rx_sync[0], rx_i};
            if (!rx_active) begin
                // Falling edge starts a frame, first sample half a bit later
                if (!rx_bit) begin
                    rx_active <= 1'b1;
                    rx_idx    <= 4'd0;
                    rx_cnt    <= BIT_HALF;
                end
            end else if (rx_cnt == BIT_LAST) begin
                rx_cnt <= '0;
                rx_idx <= rx_idx + 4'd1;
                // False start, or frame over at the stop bit
                if ((rx_idx == 4'd0 && rx_bit) || rx_idx == 4'd9) rx_active <= 1'b0;
            end else begin
                rx_cnt <= rx_cnt + 1'b1;
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (rx_active && rx_cnt == BIT_LAST && rx_idx != 4'd0 && rx_idx != 4'd9) begin
            rx_shift <= {rx_bit, rx_shift[7:1]};
        end
        if (rx_done) rx_hold <= rx_shift;
    end

    // New byte wins over a read in the same cycle
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            rx_valid <= 1'b0;
        end else if (rx_done) begin
            rx_valid <= 1'b1;
        end else if (rd_take) begin
            rx_valid <= 1'b0;
        end
    end

endmodule

// File: verilog/krz_sys_top.sv
// ================================================
// System peripheral subsystem, bridge plus GPREG and UART
// ================================================

`timescale 1ns/1ns

module krz_sys_top (
    input  logic              clk,
    input  logic              rstz,
    // Crossbar port
    input  krz_map::sys_req_t sys_req_i,
    output logic [31:0]       sys_dat_o,
    output logic              sys_ack_o,
    output logic              sys_err_o,
    // Serial lines
    input  logic              uart_rx_i,
    output logic              uart_tx_o
);
    import krz_map::*;

    // Bridge to GPREG
    gpreg_req_t  gpreg_req;
    logic [31:0] gpreg_dat;
    logic        gpreg_ack;

    // Bridge to UART
    logic [7:0]  uart_wdat;
    logic [7:0]  uart_rdat;
    logic        uart_we;
    logic        uart_stb;
    logic        uart_ack;

    krz_sysbus u_sysbus (
        .clk         (clk),
        .rstz        (rstz),
        .sys_req_i   (sys_req_i),
        .sys_dat_o   (sys_dat_o),
        .sys_ack_o   (sys_ack_o),
        .sys_err_o   (sys_err_o),
        .gpreg_req_o (gpreg_req),
        .gpreg_dat_i (gpreg_dat),
        .gpreg_ack_i (gpreg_ack),
        .uart_dat_o  (uart_wdat),
        .uart_we_o   (uart_we),
        .uart_stb_o  (uart_stb),
        .uart_dat_i  (uart_rdat),
        .uart_ack_i  (uart_ack)
    );

    krz_gpreg u_gpreg (
        .clk   (clk),
        .rstz  (rstz),
        .req_i (gpreg_req),
        .dat_o (gpreg_dat),
        .ack_o (gpreg_ack)
    );

    krz_uart u_uart (
        .clk   (clk),
        .rstz  (rstz),
        .dat_i (uart_wdat),
        .we_i  (uart_we),
        .stb_i (uart_stb),
        .dat_o (uart_rdat),
        .ack_o (uart_ack),
        .rx_i  (uart_rx_i),
        .tx_o  (uart_tx_o)
    );

endmodule

// File: verif/krz_sysbus_assert.sv
// ================================================
// Crossbar protocol checks on the system page bridge
// Bound into every krz_sysbus instance
// ================================================

`timescale 1ns/1ns

module krz_sysbus_assert (
    input  logic              clk,
    input  logic              rstz,
    input  krz_map::sys_req_t sys_req_i,
    input  logic              sys_ack_i,
    input  logic              sys_err_i,
    input  logic              req_valid_i,
    input  logic              page_gpreg_i,
    input  logic              gpreg_stb_i,
    input  logic              uart_stb_i
);

    // Failures so far, watched from the testbench
    int   fail_count = 0;
    logic stb_q;
    logic gpreg_start;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            stb_q <= 1'b0;
        end else begin
            stb_q <= sys_req_i.stb;
        end
    end

    // Rising stb with a valid GPREG request, bridge is in IDLE here
    assign gpreg_start = sys_req_i.stb & ~stb_q & req_valid_i & page_gpreg_i;

    // ================================================
    // Response strobes

    a_ack_err_excl: assert property (@(posedge clk) disable iff (!rstz)
        !(sys_ack_i && sys_err_i))
    else begin
        fail_count = fail_count + 1;
        $error("sys_ack_o and sys_err_o high in the same cycle");
    end

    a_ack_pulse: assert property (@(posedge clk) disable iff (!rstz)
        sys_ack_i |=> !sys_ack_i)
    else begin
        fail_count = fail_count + 1;
        $error("sys_ack_o longer than one cycle");
    end

    a_err_pulse: assert property (@(posedge clk) disable iff (!rstz)
        sys_err_i |=> !sys_err_i)
    else begin
        fail_count = fail_count + 1;
        $error("sys_err_o longer than one cycle");
    end

    // ================================================
    // Peripheral side and GPREG latency

    a_one_stb: assert property (@(posedge clk) disable iff (!rstz)
        !(gpreg_stb_i && uart_stb_i))
    else begin
        fail_count = fail_count + 1;
        $error("GPREG and UART strobes high together");
    end

    // Ack three cycles after the request, never earlier
    a_gpreg_ack_on_time: assert property (@(posedge clk) disable iff (!rstz)
        $past(gpreg_start, 3) |-> sys_ack_i)
    else begin
        fail_count = fail_count + 1;
        $error("GPREG ack missing three cycles after the request");
    end

    a_gpreg_ack_early: assert property (@(posedge clk) disable iff (!rstz)
        ($past(gpreg_start, 1) || $past(gpreg_start, 2)) |-> !sys_ack_i)
    else begin
        fail_count = fail_count + 1;
        $error("GPREG ack earlier than three cycles");
    end

endmodule

bind krz_sysbus krz_sysbus_assert u_sysbus_assert (
    .clk          (clk),
    .rstz         (rstz),
    .sys_req_i    (sys_req_i),
    .sys_ack_i    (sys_ack_o),
    .sys_err_i    (sys_err_o),
    .req_valid_i  (req_valid),
    .page_gpreg_i (page_gpreg),
    .gpreg_stb_i  (gpreg_stb),
    .uart_stb_i   (uart_stb_o)
);

// File: verif/tb_krz_sys.sv
// ================================================
// Testbench for the system peripheral subsystem
// UART looped back through a delay line, checks by assertions
// ================================================

`timescale 1ns/1ns

module tb_krz_sys;
    import krz_map::*;

    localparam int CLK_PERIOD = 8;
    localparam int FRAME_CLKS = 10 * UART_CLKS_PER_BIT;
    // Two frames on the wire, so a whole write ends before its echo is read
    localparam int LOOP_DELAY = 2 * FRAME_CLKS;
    // 16 UART bytes plus margin
    localparam int WATCHDOG_CYCLES = 16 * FRAME_CLKS + 200;

    localparam logic [23:0] SYS_BASE   = 24'h800000;
    localparam logic [23:0] GPREG_BASE = SYS_BASE | (24'd1 << (PAGE_LSB + PAGE_GPREG));
    localparam logic [23:0] UART_BASE  = SYS_BASE | (24'd1 << (PAGE_LSB + PAGE_UART));

    logic        clk;
    logic        rstz;
    sys_req_t    sys_req;
    logic [31:0] sys_dat;
    logic        sys_ack;
    logic        sys_err;
    logic        uart_rx;
    logic        uart_tx;

    logic [LOOP_DELAY-1:0] loop_line;
    logic [31:0] lcg_state = 32'h7e61;
    logic [31:0] gp_shadow [1:GPREG_COUNT-1];

    krz_sys_top u_krz_sys_top (
        .clk       (clk),
        .rstz      (rstz),
        .sys_req_i (sys_req),
        .sys_dat_o (sys_dat),
        .sys_ack_o (sys_ack),
        .sys_err_o (sys_err),
        .uart_rx_i (uart_rx),
        .uart_tx_o (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Serial loopback, tx back into rx
    always @(posedge clk) begin
        loop_line <= {loop_line[LOOP_DELAY-2:0], uart_tx};
    end
    assign uart_rx = loop_line[LOOP_DELAY-1];

    // ================================================
    // Helpers

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Lane 0 goes out first and ends up on top
    function automatic logic [31:0] byte_reverse(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
        fail_run("Value did not match");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else report_mismatch(name, exp, got);
    endtask

    // One crossbar transaction, stb held until ack or err
    task automatic bus_cycle(input logic [23:0] adr, input logic [31:0] wdat,
                             input logic we, input logic [3:0] sel,
                             output logic [31:0] rdat, output logic got_ack,
                             output logic got_err);
        sys_req_t req;
        req.adr = adr;
        req.dat = wdat;
        req.we  = we;
        req.sel = sel;
        req.stb = 1'b1;
        @(posedge clk);
        sys_req <= req;
        do begin
            @(negedge clk);
        end while (!sys_ack && !sys_err);
        rdat    = sys_dat;
        got_ack = sys_ack;
        got_err = sys_err;
        @(posedge clk);
        sys_req <= '0;
    endtask

    task automatic bus_write(input logic [23:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel);
        logic [31:0] rdat;
        logic        ack;
        logic        err;
        bus_cycle(adr, wdat, 1'b1, sel, rdat, ack, err);
        check_value("sys_ack_o", 32'd1, {31'd0, ack});
    endtask

    task automatic bus_read(input logic [23:0] adr, input logic [3:0] sel,
                            output logic [31:0] rdat);
        logic ack;
        logic err;
        bus_cycle(adr, 32'h0, 1'b0, sel, rdat, ack, err);
        check_value("sys_ack_o", 32'd1, {31'd0, ack});
    endtask

    task automatic bus_error(input logic [23:0] adr, input logic [3:0] sel);
        logic [31:0] rdat;
        logic        ack;
        logic        err;
        bus_cycle(adr, 32'h0, 1'b0, sel, rdat, ack, err);
        check_value("sys_err_o", 32'd1, {31'd0, err});
        check_value("sys_ack_o", 32'd0, {31'd0, ack});
    endtask

    // ================================================
    // Tests

    task automatic test_gpreg();
        logic [31:0] rdat;
        for (int i = 1; i < GPREG_COUNT; i++) begin
            gp_shadow[i] = next_random();
            bus_write(GPREG_BASE + 24'(4 * i), gp_shadow[i], 4'b1111);
        end
        for (int i = 1; i < GPREG_COUNT; i++) begin
            bus_read(GPREG_BASE + 24'(4 * i), 4'b1111, rdat);
            check_value("sys_dat_o", gp_shadow[i], rdat);
        end
        // ID word survives a write
        bus_write(GPREG_BASE, next_random(), 4'b1111);
        bus_read(GPREG_BASE, 4'b1111, rdat);
        check_value("sys_dat_o", GPREG_ID, rdat);
    endtask

    task automatic test_uart();
        logic [31:0] word;
        logic [31:0] rdat;
        word = next_random();
        bus_write(UART_BASE, word, 4'b1111);
        bus_read(UART_BASE, 4'b1111, rdat);
        check_value("sys_dat_o", byte_reverse(word), rdat);
        // Single byte
        word = next_random();
        bus_write(UART_BASE, word, 4'b0001);
        bus_read(UART_BASE, 4'b0001, rdat);
        check_value("sys_dat_o", {24'h0, word[7:0]}, rdat);
        // Half word, b0 lands in bits 15:8
        word = next_random();
        bus_write(UART_BASE, word, 4'b0011);
        bus_read(UART_BASE, 4'b0011, rdat);
        check_value("sys_dat_o", {16'h0, word[7:0], word[15:8]}, rdat);
    endtask

    task automatic test_errors();
        logic [31:0] rdat;
        bus_error(GPREG_BASE + 24'h2, 4'b1111);
        bus_error(GPREG_BASE + 24'h4, 4'b0111);
        bus_error(SYS_BASE + 24'h4, 4'b1111);
        // Bridge back in IDLE
        bus_read(GPREG_BASE + 24'd12, 4'b1111, rdat);
        check_value("sys_dat_o", gp_shadow[3], rdat);
    endtask

    // ================================================
    // Main sequence, watchdog and assertion watch

    initial begin
        sys_req   = '0;
        rstz      = 1'b0;
        loop_line = '1;
        repeat (2) @(posedge clk);
        rstz <= 1'b1;
        @(negedge clk);
        check_value("sys_ack_o", 32'd0, {31'd0, sys_ack});
        check_value("sys_err_o", 32'd0, {31'd0, sys_err});
        check_value("uart_tx_o", 32'd1, {31'd0, uart_tx});
        test_gpreg();
        test_uart();
        test_errors();
        @(negedge clk);
        if (u_krz_sys_top.u_sysbus.u_sysbus_assert.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_run("Bus protocol assertion failed in the bridge");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Watchdog expired, the DUT stopped answering");
    end

    always @(negedge clk) begin
        if (u_krz_sys_top.u_sysbus.u_sysbus_assert.fail_count != 0) begin
            fail_run("Bus protocol assertion failed in the bridge");
        end
    end

endmodule

// File: build.f
verilog/krz_map.sv
verilog/krz_sysbus.sv
verilog/krz_gpreg.sv
verilog/krz_uart.sv
verilog/krz_sys_top.sv
verif/krz_sysbus_assert.sv
verif/tb_krz_sys.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then search the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_krz_sys -f build.f -o sim_krz_sys \
    || { echo "Verilator build failed"; exit 1; }
# Assertion errors must not stop the run before the testbench reports them
out=$(./obj_dir/sim_krz_sys +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "Everything OK" \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
